/* include/opl3_consts.svh */
`ifndef OPL3_CONSTS_SVH
`define OPL3_CONSTS_SVH

// register addresses, bank 0 only
`define OPL3_REG_TIMER1     8'h02  // timer 1 preset
`define OPL3_REG_TIMER2     8'h03  // timer 2 preset
`define OPL3_REG_TIMER_CTRL 8'h04  // irq reset, masks, start bits

// control register bit positions
`define OPL3_BIT_RST_IRQ 7  // write-only command, clears both flags
`define OPL3_BIT_MASK1   6  // mask timer 1 overflow
`define OPL3_BIT_MASK2   5  // mask timer 2 overflow
`define OPL3_BIT_START2  1  // run timer 2
`define OPL3_BIT_START1  0  // run timer 1

// clk_host cycles per timer tick, keep the 1:4 ratio
`define OPL3_TICK1_CYCLES 40   // stands in for 80 us
`define OPL3_TICK2_CYCLES 160  // stands in for 320 us

`define OPL3_NUM_TIMERS 2  // timers in the generate loop

`define OPL3_TRICK_READS 50  // host reads that force the timer 1 flag

`endif

/* rtl/opl3_pkg.sv */
`include "opl3_consts.svh"

package opl3_pkg;

    typedef logic [7:0] opl3_data_t;      // host bus byte and register data
    typedef logic [7:0] opl3_reg_addr_t;  // register index within a bank
    typedef logic       opl3_bank_t;      // 0 = bank 0, 1 = bank 1

    // one bit per timer, index 0 is timer 1
    typedef logic [`OPL3_NUM_TIMERS-1:0] opl3_timer_vec_t;

    // true when a latched write targets the given bank 0 register
    function automatic logic is_bank0_reg(
        input opl3_bank_t     bank,
        input opl3_reg_addr_t addr,
        input opl3_reg_addr_t target
    );
        return (bank == 1'b0) && (addr == target);
    endfunction

endpackage

/* rtl/opl3_host_if.sv */
`include "opl3_consts.svh"

module opl3_host_if (
    input  logic                      clk_host,
    input  logic                      arst_n,
    input  logic                      ic_n,
    input  logic                      cs_n,
    input  logic                      rd_n,
    input  logic                      wr_n,
    input  logic [1:0]                address,
    input  opl3_pkg::opl3_data_t      din,
    output logic                      reg_wr_valid,
    output opl3_pkg::opl3_bank_t      reg_wr_bank,
    output opl3_pkg::opl3_reg_addr_t  reg_wr_addr,
    output opl3_pkg::opl3_data_t      reg_wr_data,
    output logic                      host_rd,
    output opl3_pkg::opl3_timer_vec_t load,
    output opl3_pkg::opl3_data_t      preset_data,
    output opl3_pkg::opl3_timer_vec_t ctrl_wr,
    output opl3_pkg::opl3_timer_vec_t start_bits,
    output opl3_pkg::opl3_timer_vec_t mask_bits,
    output logic                      rst_irq
);
    import opl3_pkg::*;

    logic wr;        // write strobe active
    logic rd;        // read strobe active
    logic wr_q;      // strobe history for edge detect
    logic rd_q;
    logic wr_rise;   // first cycle of a write
    logic rd_start;  // first cycle of a read
    logic ctrl_sel;  // data write to the control register
    logic irq_cmd;   // control write is a reset-interrupt command

    assign wr       = ~cs_n & ~wr_n;
    assign rd       = ~cs_n & ~rd_n;
    assign wr_rise  = wr & ~wr_q;  // long strobe counts once
    assign rd_start = rd & ~rd_q;

    always_ff @(posedge clk_host or negedge arst_n) begin
        if (!arst_n) begin
            wr_q         <= 1'b0;
            rd_q         <= 1'b0;
            host_rd      <= 1'b0;
            reg_wr_valid <= 1'b0;
            reg_wr_bank  <= 1'b0;
            reg_wr_addr  <= '0;
            reg_wr_data  <= '0;
        end else if (!ic_n) begin
            wr_q         <= 1'b0;
            rd_q         <= 1'b0;
            host_rd      <= 1'b0;
            reg_wr_valid <= 1'b0;
            reg_wr_bank  <= 1'b0;
            reg_wr_addr  <= '0;
            reg_wr_data  <= '0;
        end else begin
            wr_q         <= wr;
            rd_q         <= rd;
            host_rd      <= rd_start;  // one pulse per read access
            reg_wr_valid <= 1'b0;
            if (wr_rise) begin
                if (!address[0]) begin  // address phase
                    reg_wr_bank <= address[1];
                    reg_wr_addr <= din;
                end else begin          // data phase, fires the write
                    reg_wr_valid <= 1'b1;
                    reg_wr_data  <= din;
                end
            end
        end
    end

    // timer register decode, same cycle as reg_wr_valid
    assign ctrl_sel = reg_wr_valid & is_bank0_reg(reg_wr_bank, reg_wr_addr, `OPL3_REG_TIMER_CTRL);
    assign irq_cmd  = reg_wr_data[`OPL3_BIT_RST_IRQ];

    assign load[0] = reg_wr_valid & is_bank0_reg(reg_wr_bank, reg_wr_addr, `OPL3_REG_TIMER1);
    assign load[1] = reg_wr_valid & is_bank0_reg(reg_wr_bank, reg_wr_addr, `OPL3_REG_TIMER2);
    assign preset_data = reg_wr_data;

    // bit 7 set means irq reset only, the rest of the byte is ignored
    assign rst_irq    = ctrl_sel & irq_cmd;
    assign ctrl_wr    = {`OPL3_NUM_TIMERS{ctrl_sel & ~irq_cmd}};
    assign start_bits = irq_cmd ? '0 : {reg_wr_data[`OPL3_BIT_START2],
                                        reg_wr_data[`OPL3_BIT_START1]};
    assign mask_bits  = irq_cmd ? '0 : {reg_wr_data[`OPL3_BIT_MASK2],
                                        reg_wr_data[`OPL3_BIT_MASK1]};

endmodule

/* rtl/opl3_tick_gen.sv */
`include "opl3_consts.svh"

module opl3_tick_gen (
    input  logic                      clk_host,
    input  logic                      arst_n,
    input  logic                      ic_n,
    output opl3_pkg::opl3_timer_vec_t tick
);
    localparam int BASE_CYCLES = `OPL3_TICK1_CYCLES;
    localparam int DIV         = `OPL3_TICK2_CYCLES / `OPL3_TICK1_CYCLES;  // 4
    localparam int BASE_W      = $clog2(BASE_CYCLES);
    localparam int DIV_W       = $clog2(DIV);

    logic [BASE_W-1:0] base_cnt;   // clk_host cycles within one timer 1 tick
    logic [DIV_W-1:0]  div_cnt;    // timer 1 ticks within one timer 2 tick
    logic              base_wrap;

    assign base_wrap = (base_cnt == BASE_W'(BASE_CYCLES - 1));

    always_ff @(posedge clk_host or negedge arst_n) begin
        if (!arst_n) begin
            base_cnt <= '0;
            div_cnt  <= '0;
            tick     <= '0;
        end else if (!ic_n) begin
            base_cnt <= '0;
            div_cnt  <= '0;
            tick     <= '0;
        end else begin
            base_cnt <= base_wrap ? '0 : base_cnt + 1'b1;
            if (base_wrap) begin
                div_cnt <= (div_cnt == DIV_W'(DIV - 1)) ? '0 : div_cnt + 1'b1;
            end
            tick[0] <= base_wrap;                                  // 80 us tick
            tick[1] <= base_wrap && (div_cnt == DIV_W'(DIV - 1));  // 320 us tick
        end
    end

endmodule

/* rtl/opl3_timer.sv */
module opl3_timer (
    input  logic                 clk_host,
    input  logic                 arst_n,
    input  logic                 ic_n,
    input  logic                 tick,
    input  logic                 load,
    input  logic                 ctrl_wr,
    input  logic                 start,
    input  opl3_pkg::opl3_data_t preset_data,
    output logic                 ovf
);
    import opl3_pkg::*;

    opl3_data_t preset;  // reload value from reg 0x02 or 0x03
    opl3_data_t count;   // counts up, overflows after 8'hff
    logic       run;

    always_ff @(posedge clk_host or negedge arst_n) begin
        if (!arst_n) begin
            preset <= '0;
            count  <= '0;
            run    <= 1'b0;
            ovf    <= 1'b0;
        end else if (!ic_n) begin
            preset <= '0;
            count  <= '0;
            run    <= 1'b0;
            ovf    <= 1'b0;
        end else begin
            ovf <= 1'b0;
            if (load) begin
                preset <= preset_data;  // takes effect on next start or wrap
            end

            if (ctrl_wr) begin
                run <= start;
                if (start) begin
                    count <= preset;  // a start always restarts from the preset
                end
            end else if (run && tick) begin
                if (count == 8'hff) begin
                    count <= preset;
                    ovf   <= 1'b1;
                end else begin
                    count <= count + 8'd1;
                end
            end
        end
    end

endmodule

/* rtl/opl3_status.sv */
module opl3_status (
    input  logic                      clk_host,
    input  logic                      arst_n,
    input  logic                      ic_n,
    input  opl3_pkg::opl3_timer_vec_t ovf,
    input  opl3_pkg::opl3_timer_vec_t mask_bits,
    input  opl3_pkg::opl3_timer_vec_t ctrl_wr,
    input  logic                      rst_irq,
    input  logic                      force_ovf1,
    input  logic                      rd,
    input  logic                      address,   // bus address bit 0
    output opl3_pkg::opl3_data_t      dout,
    output logic                      irq_n
);
    import opl3_pkg::*;

    opl3_timer_vec_t mask_q;    // per-timer overflow mask
    opl3_timer_vec_t flag;      // sticky overflow flags
    opl3_timer_vec_t flag_set;  // unmasked overflow or forced
    logic            irq;

    always_comb begin
        flag_set    = ovf & ~mask_q;
        flag_set[0] = flag_set[0] | force_ovf1;  // detection trick hits timer 1 only
    end

    always_ff @(posedge clk_host or negedge arst_n) begin
        if (!arst_n) begin
            mask_q <= '0;
            flag   <= '0;
        end else if (!ic_n) begin
            mask_q <= '0;
            flag   <= '0;
        end else begin
            mask_q <= (ctrl_wr & mask_bits) | (~ctrl_wr & mask_q);
            if (rst_irq) begin
                flag <= '0;  // clear wins over a set in the same cycle
            end else begin
                flag <= flag | flag_set;
            end
        end
    end

    assign irq   = |flag;
    assign irq_n = ~irq;

    // status byte: irq, flag 1, flag 2, unused low bits
    assign dout = (rd && !address) ? {irq, flag[0], flag[1], 5'b0_0000} : '0;

endmodule

/* rtl/trick_sw_detection.sv */
`include "opl3_consts.svh"

module trick_sw_detection (
    input  logic                     clk_host,
    input  logic                     arst_n,
    input  logic                     ic_n,
    input  logic                     reg_wr_valid,
    input  opl3_pkg::opl3_bank_t     reg_wr_bank,
    input  opl3_pkg::opl3_reg_addr_t reg_wr_addr,
    input  opl3_pkg::opl3_data_t     reg_wr_data,
    input  logic                     host_rd,
    output logic                     force_ovf1
);
    import opl3_pkg::*;

    localparam int CNT_W = $clog2(`OPL3_TRICK_READS);

    opl3_data_t       timer1_mirror;  // copy of the timer 1 preset
    logic [CNT_W-1:0] rd_cnt;         // host reads since arming
    logic             armed;
    logic             start1_wr;      // control write that starts timer 1
    logic             last_rd;        // read that reaches the trigger count

    assign start1_wr = reg_wr_valid
                     & is_bank0_reg(reg_wr_bank, reg_wr_addr, `OPL3_REG_TIMER_CTRL)
                     & ~reg_wr_data[`OPL3_BIT_RST_IRQ]
                     & reg_wr_data[`OPL3_BIT_START1];
    assign last_rd   = armed & host_rd & (rd_cnt == CNT_W'(`OPL3_TRICK_READS - 1));

    always_ff @(posedge clk_host or negedge arst_n) begin
        if (!arst_n) begin
            timer1_mirror <= '0;
            rd_cnt        <= '0;
            armed         <= 1'b0;
            force_ovf1    <= 1'b0;
        end else if (!ic_n) begin
            timer1_mirror <= '0;
            rd_cnt        <= '0;
            armed         <= 1'b0;
            force_ovf1    <= 1'b0;
        end else begin
            force_ovf1 <= last_rd;  // single pulse, one cycle after the last read
            if (reg_wr_valid && is_bank0_reg(reg_wr_bank, reg_wr_addr, `OPL3_REG_TIMER1)) begin
                timer1_mirror <= reg_wr_data;
            end

            if (start1_wr) begin
                armed  <= (timer1_mirror == 8'hff);  // only the max preset is a probe
                rd_cnt <= '0;
            end else if (reg_wr_valid || last_rd) begin
                armed  <= 1'b0;  // any other write cancels, firing disarms
                rd_cnt <= '0;
            end else if (armed && host_rd) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

endmodule

/* rtl/opl3_timers_top.sv */
`include "opl3_consts.svh"

module opl3_timers_top (
    input  logic                 clk_host,
    input  logic                 arst_n,
    input  logic                 ic_n,
    input  logic                 cs_n,
    input  logic                 rd_n,
    input  logic                 wr_n,
    input  logic [1:0]           address,
    input  opl3_pkg::opl3_data_t din,
    output opl3_pkg::opl3_data_t dout,
    output logic                 irq_n
);
    import opl3_pkg::*;

    logic            reg_wr_valid;  // decoded register write
    opl3_bank_t      reg_wr_bank;
    opl3_reg_addr_t  reg_wr_addr;
    opl3_data_t      reg_wr_data;
    logic            host_rd;       // one pulse per host read
    opl3_timer_vec_t load;
    opl3_data_t      preset_data;
    opl3_timer_vec_t ctrl_wr;
    opl3_timer_vec_t start_bits;
    opl3_timer_vec_t mask_bits;
    logic            rst_irq;
    opl3_timer_vec_t tick;
    opl3_timer_vec_t ovf;
    logic            force_ovf1;    // detection trick pulse

    opl3_host_if u_host_if (
        .clk_host     (clk_host),
        .arst_n       (arst_n),
        .ic_n         (ic_n),
        .cs_n         (cs_n),
        .rd_n         (rd_n),
        .wr_n         (wr_n),
        .address      (address),
        .din          (din),
        .reg_wr_valid (reg_wr_valid),
        .reg_wr_bank  (reg_wr_bank),
        .reg_wr_addr  (reg_wr_addr),
        .reg_wr_data  (reg_wr_data),
        .host_rd      (host_rd),
        .load         (load),
        .preset_data  (preset_data),
        .ctrl_wr      (ctrl_wr),
        .start_bits   (start_bits),
        .mask_bits    (mask_bits),
        .rst_irq      (rst_irq)
    );

    opl3_tick_gen u_tick_gen (
        .clk_host (clk_host),
        .arst_n   (arst_n),
        .ic_n     (ic_n),
        .tick     (tick)
    );

    // timer 1 on index 0, timer 2 on index 1
    for (genvar i = 0; i < `OPL3_NUM_TIMERS; i++) begin : g_timer
        opl3_timer u_timer (
            .clk_host    (clk_host),
            .arst_n      (arst_n),
            .ic_n        (ic_n),
            .tick        (tick[i]),
            .load        (load[i]),
            .ctrl_wr     (ctrl_wr[i]),
            .start       (start_bits[i]),
            .preset_data (preset_data),
            .ovf         (ovf[i])
        );
    end

    opl3_status u_status (
        .clk_host   (clk_host),
        .arst_n     (arst_n),
        .ic_n       (ic_n),
        .ovf        (ovf),
        .mask_bits  (mask_bits),
        .ctrl_wr    (ctrl_wr),
        .rst_irq    (rst_irq),
        .force_ovf1 (force_ovf1),
        .rd         (~(cs_n | rd_n)),  // read strobe level
        .address    (address[0]),
        .dout       (dout),
        .irq_n      (irq_n)
    );

    trick_sw_detection u_trick_sw_detection (
        .clk_host     (clk_host),
        .arst_n       (arst_n),
        .ic_n         (ic_n),
        .reg_wr_valid (reg_wr_valid),
        .reg_wr_bank  (reg_wr_bank),
        .reg_wr_addr  (reg_wr_addr),
        .reg_wr_data  (reg_wr_data),
        .host_rd      (host_rd),
        .force_ovf1   (force_ovf1)
    );

endmodule

/* tb/opl3_timers_assert.sv */
module opl3_timers_assert (
    input logic                      clk_host,
    input logic                      arst_n,
    input logic                      ic_n,
    input logic                      irq_n,
    input opl3_pkg::opl3_timer_vec_t ovf,
    input opl3_pkg::opl3_timer_vec_t mask_q,   // status block mask register
    input opl3_pkg::opl3_timer_vec_t flag,     // status block sticky flags
    input logic                      force_ovf1,
    input logic                      rst_irq
);
    int   fail_cnt = 0;  // assertion failures so far
    logic set_cause;     // unmasked overflow on either timer, or the force pulse

    assign set_cause = force_ovf1 | (|(ovf & ~mask_q));

    // irq inactive while reset is held and on the first edge after release
    irq_in_reset: assert property (@(posedge clk_host) !arst_n |=> irq_n)
        else begin
            $error("irq_n low during or just after reset");
            fail_cnt++;
        end

    // irq drops one cycle after a set cause and stays low until rst_irq or ic_n
    irq_matches_flags: assert property (@(posedge clk_host) disable iff (!arst_n)
        !irq_n == ($past(ic_n && !rst_irq) && ($past(!irq_n) || $past(set_cause))))
        else begin
            $error("irq_n does not follow the status flags");
            fail_cnt++;
        end

    // timer 1 flag also takes the detection trick pulse
    flag1_cause: assert property (@(posedge clk_host) disable iff (!arst_n)
        $rose(flag[0]) |-> $past(force_ovf1 || (ovf[0] && !mask_q[0])))
        else begin
            $error("flag 1 rose without an unmasked overflow or force pulse");
            fail_cnt++;
        end

    flag2_cause: assert property (@(posedge clk_host) disable iff (!arst_n)
        $rose(flag[1]) |-> $past(ovf[1] && !mask_q[1]))
        else begin
            $error("flag 2 rose without an unmasked overflow");
            fail_cnt++;
        end

    rst_irq_clears: assert property (@(posedge clk_host) disable iff (!arst_n)
        rst_irq |=> (flag == '0))
        else begin
            $error("rst_irq did not clear both flags");
            fail_cnt++;
        end

endmodule

bind opl3_timers_top opl3_timers_assert u_assert (
    .clk_host   (clk_host),
    .arst_n     (arst_n),
    .ic_n       (ic_n),
    .irq_n      (irq_n),
    .ovf        (ovf),
    .mask_q     (u_status.mask_q),
    .flag       (u_status.flag),
    .force_ovf1 (force_ovf1),
    .rst_irq    (rst_irq)
);

/* tb/opl3_timers_tb.sv */
`include "opl3_consts.svh"

module opl3_timers_tb;
    localparam int NUM_TESTS   = 5;
    localparam int BUS_CYCLES  = 1000;  // bus traffic allowance per test
    localparam int TEST_BUDGET = 256 * `OPL3_TICK2_CYCLES + BUS_CYCLES;
    localparam logic [7:0] CTRL_START1 = 8'(1 << `OPL3_BIT_START1);
    localparam logic [7:0] CTRL_START2 = 8'(1 << `OPL3_BIT_START2);
    localparam logic [7:0] CTRL_MASK1  = 8'(1 << `OPL3_BIT_MASK1);
    localparam logic [7:0] CTRL_RST    = 8'(1 << `OPL3_BIT_RST_IRQ);

    logic       clk_host;
    logic       arst_n;
    logic       ic_n;
    logic       cs_n;
    logic       rd_n;
    logic       wr_n;
    logic [1:0] address;
    logic [7:0] din;
    logic [7:0] dout;
    logic       irq_n;

    int seed = 32'h8bad6fc4;
    int errors;        // tb-side check failures
    int tests_run;
    int tests_failed;
    int err_mark;      // error total at the start of the current test

    opl3_timers_top u_opl3_timers_top (
        .clk_host (clk_host),
        .arst_n   (arst_n),
        .ic_n     (ic_n),
        .cs_n     (cs_n),
        .rd_n     (rd_n),
        .wr_n     (wr_n),
        .address  (address),
        .din      (din),
        .dout     (dout),
        .irq_n    (irq_n)
    );

    always #5 clk_host = ~clk_host;

    function automatic int total_errors();
        return errors + u_opl3_timers_top.u_assert.fail_cnt;  // tb checks plus bound ones
    endfunction

    // status byte layout: irq, flag 1, flag 2, zeros
    function automatic logic [7:0] status_byte(input logic f1, input logic f2);
        return {f1 | f2, f1, f2, 5'b0_0000};
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_host);
    endtask

    task automatic idle_gap();
        wait_cycles($unsigned($random(seed)) % 4);  // 0 to 3 idle cycles
    endtask

    task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
        @(posedge clk_host);
        cs_n    <= 1'b0;
        wr_n    <= 1'b0;
        address <= a;
        din     <= d;
        @(posedge clk_host);
        cs_n <= 1'b1;  // strobe drops so the next write has a fresh edge
        wr_n <= 1'b1;
        idle_gap();
    endtask

    task automatic reg_write(input logic [7:0] reg_addr, input logic [7:0] data);
        bus_write(2'b00, reg_addr);  // address phase, bank 0
        bus_write(2'b01, data);      // data phase
    endtask

    task automatic status_read(output logic [7:0] val);
        @(posedge clk_host);
        cs_n    <= 1'b0;
        rd_n    <= 1'b0;
        address <= 2'b00;
        @(negedge clk_host);
        val = dout;  // mid-cycle, dout settled
        @(posedge clk_host);
        cs_n <= 1'b1;
        rd_n <= 1'b1;
    endtask

    task automatic check_status(input logic [7:0] exp, input string what);
        logic [7:0] got;
        status_read(got);
        assert (got === exp)
            else begin
                $display("Mismatch at %0t: %s, status 0x%02h, expected 0x%02h",
                         $time, what, got, exp);
                errors++;
            end
    endtask

    task automatic read_burst(input int n);
        repeat (n) check_status(8'h00, "status during read burst");
    endtask

    task automatic stop_and_clear();
        reg_write(`OPL3_REG_TIMER_CTRL, 8'h00);     // stop both timers, unmask
        reg_write(`OPL3_REG_TIMER_CTRL, CTRL_RST);  // drop both flags
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (total_errors() == err_mark) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL", tests_run, name);
        end
        err_mark = total_errors();
    endtask

    initial begin
        wait_cycles(4 + NUM_TESTS * TEST_BUDGET);
        $display("watchdog expired, the tests did not finish in time");
        $display("Something failed");
        $finish;
    end

    initial begin
        logic [7:0] p;
        logic [7:0] p1;
        int         early;
        clk_host     = 1'b0;
        arst_n       = 1'b0;
        ic_n         = 1'b1;
        cs_n         = 1'b1;
        rd_n         = 1'b1;
        wr_n         = 1'b1;
        address      = 2'b00;
        din          = 8'h00;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        err_mark     = 0;
        wait_cycles(4);
        arst_n <= 1'b1;
        wait_cycles(2);

        check_status(8'h00, "status after reset");
        assert (irq_n === 1'b1)
            else begin
                $display("Mismatch at %0t: irq_n is %b after reset, expected 1",
                         $time, irq_n);
                errors++;
            end
        end_test("reset state");

        p = 8'hc0 + 8'($unsigned($random(seed)) % 63);  // c0 to fe
        reg_write(`OPL3_REG_TIMER1, p);
        reg_write(`OPL3_REG_TIMER_CTRL, CTRL_START1);
        early = (255 - p) * `OPL3_TICK1_CYCLES - 10;  // before the earliest overflow
        wait_cycles(early);
        check_status(8'h00, "timer 1 flag set too early");
        wait_cycles((257 - p) * `OPL3_TICK1_CYCLES - early);
        check_status(status_byte(1'b1, 1'b0), "timer 1 overflow");
        stop_and_clear();
        check_status(8'h00, "flags after rst_irq");
        end_test("timer 1 overflow");

        p1 = 8'($random(seed));
        p  = 8'hf0 + 8'($unsigned($random(seed)) % 15);  // f0 to fe
        reg_write(`OPL3_REG_TIMER1, p1);
        reg_write(`OPL3_REG_TIMER2, p);
        reg_write(`OPL3_REG_TIMER_CTRL, CTRL_MASK1 | CTRL_START1 | CTRL_START2);
        early = (255 - p) * `OPL3_TICK2_CYCLES - 10;
        wait_cycles(early);
        check_status(8'h00, "timer 2 flag set too early");
        wait_cycles((257 - p) * `OPL3_TICK2_CYCLES - early);
        check_status(status_byte(1'b0, 1'b1), "timer 2 overflow, timer 1 masked");
        stop_and_clear();
        check_status(8'h00, "flags after rst_irq");
        end_test("masking and timer 2");

        // timer 1 masked so only the force pulse can set flag 1
        reg_write(`OPL3_REG_TIMER1, 8'hff);
        reg_write(`OPL3_REG_TIMER_CTRL, CTRL_MASK1 | CTRL_START1);
        read_burst(`OPL3_TRICK_READS);
        wait_cycles(3);  // force one cycle after the read, flag one after that
        check_status(status_byte(1'b1, 1'b0), "flag 1 after detection reads");
        stop_and_clear();
        check_status(8'h00, "flags after rst_irq");
        end_test("detection trick");

        reg_write(`OPL3_REG_TIMER1, 8'hfe);  // not the probe preset
        reg_write(`OPL3_REG_TIMER_CTRL, CTRL_MASK1 | CTRL_START1);
        read_burst(`OPL3_TRICK_READS);
        wait_cycles(3);
        check_status(8'h00, "flag 1 forced with preset fe");
        stop_and_clear();
        reg_write(`OPL3_REG_TIMER1, 8'hff);
        reg_write(`OPL3_REG_TIMER_CTRL, CTRL_MASK1 | CTRL_START1);
        read_burst(`OPL3_TRICK_READS / 2);
        reg_write(`OPL3_REG_TIMER2, 8'($random(seed)));  // unrelated write disarms
        read_burst(`OPL3_TRICK_READS - `OPL3_TRICK_READS / 2);
        wait_cycles(3);
        check_status(8'h00, "flag 1 forced after an interrupting write");
        stop_and_clear();
        end_test("trick cancel");

        wait_cycles(2);  // let the bound assertions see the last cycles
        $display("%0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+include
rtl/opl3_pkg.sv
rtl/opl3_host_if.sv
rtl/opl3_tick_gen.sv
rtl/opl3_timer.sv
rtl/opl3_status.sv
rtl/trick_sw_detection.sv
rtl/opl3_timers_top.sv
tb/opl3_timers_assert.sv
tb/opl3_timers_tb.sv
